// File: hdl/line_buf_pkg.sv
// shared constants and state types for the bicubic line buffer, imported by every RTL module
package line_buf_pkg;

    // five row memories: four feed the window, one takes the incoming row
    localparam int num_banks = 5;

    // bicubic kernel needs a 4x4 neighbourhood
    localparam int win_size = 4;

    typedef logic [2:0] bank_sel_t;  // row memory index 0..4

    // input side
    typedef enum logic {
        wr_fill,  // accepting pixels of a row
        wr_hold   // next bank still read, or whole frame received
    } wr_state_t;

    // output side
    typedef enum logic [1:0] {
        rd_wait,   // waiting until the rows for the next output row are stored
        rd_prime,  // first three column reads of a row
        rd_run,    // one read per window
        rd_last    // frame done pulse
    } rd_state_t;

endpackage

// File: hdl/row_ram.sv
// one image row of storage, written by the row writer and read by the window reader
`timescale 1ns/1ps

module row_ram #(
    parameter int  depth      = 8,
    parameter int  data_width = 24,
    localparam int addr_w     = (depth > 1) ? $clog2(depth) : 1
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [addr_w-1:0]     wr_addr,
    input  logic [data_width-1:0] wr_data,
    input  logic                  rd_en,
    input  logic [addr_w-1:0]     rd_addr,
    output logic [data_width-1:0] rd_data
);

    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data holds until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // both column counters must stay inside the row
    a_addr_range: assert property (@(posedge clk)
        !(wr_en && (wr_addr >= depth)) && !(rd_en && (rd_addr >= depth)));

endmodule

// File: hdl/row_writer.sv
// input side of the line buffer: accepts raster pixels and fills the row memories in turn
`timescale 1ns/1ps

module row_writer #(
    parameter int  img_width   = 8,
    parameter int  img_height  = 6,
    parameter int  pixel_width = 24,
    localparam int addr_w      = (img_width > 1) ? $clog2(img_width) : 1,
    localparam int row_w       = $clog2(img_height + 1)
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [pixel_width-1:0]             in_pix,
    output logic [line_buf_pkg::num_banks-1:0] wr_en,
    output logic [addr_w-1:0]                  wr_addr,
    output logic [pixel_width-1:0]             wr_data,
    output logic [row_w-1:0]                   rows_written,
    input  logic [row_w-1:0]                   cur_row,
    input  logic                               frame_done
);
    import line_buf_pkg::*;

    wr_state_t         wr_state;
    logic [addr_w-1:0] col;
    logic [row_w-1:0]  in_row;      // row being accepted, runs ahead of rows_written
    logic [row_w-1:0]  in_row_nxt;
    bank_sel_t         wr_bank;
    logic              accept;
    logic              row_end;
    logic              wr_last;     // last pixel of a row sits on the write port
    logic              fill_ok;

    assign in_ready = (wr_state == wr_fill);
    assign accept   = in_valid && in_ready;
    assign row_end  = accept && (col == addr_w'(img_width - 1));

    always_comb begin
        in_row_nxt = in_row;
        if (frame_done) begin
            in_row_nxt = '0;
        end else if (row_end) begin
            in_row_nxt = in_row + 1'b1;
        end
    end

    // row n shares a bank with row n-5, so stay within cur_row+3
    assign fill_ok = (in_row_nxt < row_w'(img_height)) &&
                     ({1'b0, in_row_nxt} <= ({1'b0, cur_row} + (row_w + 1)'(3)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state     <= wr_fill;
            col          <= '0;
            in_row       <= '0;
            wr_bank      <= '0;
            wr_en        <= '0;
            wr_last      <= 1'b0;
            rows_written <= '0;
        end else begin
            wr_state <= fill_ok ? wr_fill : wr_hold;
            in_row   <= in_row_nxt;
            wr_en    <= accept ? ({{(num_banks - 1){1'b0}}, 1'b1} << wr_bank) : '0;
            wr_last  <= row_end;
            if (accept) begin
                col <= row_end ? '0 : col + 1'b1;
            end
            if (row_end) begin  // bank count carries on across frames
                wr_bank <= (wr_bank == bank_sel_t'(num_banks - 1)) ? '0 : wr_bank + 1'b1;
            end
            if (frame_done) begin
                rows_written <= '0;
            end else if (wr_last) begin
                rows_written <= rows_written + 1'b1;  // same edge the pixel lands
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr <= col;
            wr_data <= in_pix;
        end
    end

    a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr_en));

endmodule

// File: hdl/window_reader.sv
// output side of the line buffer: reads four rows per column and builds each 4x4 window
`timescale 1ns/1ps

module window_reader #(
    parameter int  img_width   = 8,
    parameter int  img_height  = 6,
    parameter int  pixel_width = 24,
    localparam int addr_w      = (img_width > 1) ? $clog2(img_width) : 1,
    localparam int row_w       = $clog2(img_height + 1)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [row_w-1:0]       rows_written,
    output logic [row_w-1:0]       cur_row,
    output logic                   rd_en,
    output logic [addr_w-1:0]      rd_addr,
    input  logic [pixel_width-1:0] rd_data0,
    input  logic [pixel_width-1:0] rd_data1,
    input  logic [pixel_width-1:0] rd_data2,
    input  logic [pixel_width-1:0] rd_data3,
    input  logic [pixel_width-1:0] rd_data4,
    output logic                   win_valid,
    input  logic                   win_ready,
    output logic [line_buf_pkg::win_size*line_buf_pkg::win_size*pixel_width-1:0] win_pix,
    output logic                   frame_done
);
    import line_buf_pkg::*;

    localparam int k_w = $clog2(img_width + 4);  // read index 0..img_width+3

    rd_state_t              rd_state;
    bank_sel_t              cur_bank;   // bank holding cur_row
    logic [k_w-1:0]         rd_k;
    logic [k_w-1:0]         rd_col;
    logic [row_w:0]         row_plus3;
    logic                   rows_ready;
    logic                   row_first;
    logic                   row_last;
    logic                   row_near_last;
    logic                   hold;
    logic                   active;
    logic                   shift;
    logic                   xfer;
    logic                   row_done;
    logic                   rd_pend;    // read data waiting to be shifted in
    logic                   pend_win;
    logic                   pend_last;
    logic                   win_last;
    logic [1:0]             row_off  [win_size];
    bank_sel_t              row_bank [win_size];
    logic [pixel_width-1:0] row_pix  [win_size];
    logic [pixel_width-1:0] bank_data [num_banks];
    logic [pixel_width-1:0] win_q [win_size][win_size];

    // bank of row cur_row-1+off, wrapping over the five banks
    function automatic bank_sel_t bank_of(bank_sel_t base, logic [1:0] off);
        int sum;
        sum = int'(base) + num_banks - 1 + int'(off);
        if (sum >= 2 * num_banks) begin
            sum = sum - 2 * num_banks;
        end else if (sum >= num_banks) begin
            sum = sum - num_banks;
        end
        return bank_sel_t'(sum);
    endfunction

    assign bank_data[0] = rd_data0;
    assign bank_data[1] = rd_data1;
    assign bank_data[2] = rd_data2;
    assign bank_data[3] = rd_data3;
    assign bank_data[4] = rd_data4;

    // rows_written > min(r+2, h-1)
    assign row_plus3  = {1'b0, cur_row} + (row_w + 1)'(3);
    assign rows_ready = ({1'b0, rows_written} >= row_plus3) ||
                        (rows_written == row_w'(img_height));

    assign row_first     = (cur_row == '0);
    assign row_last      = (cur_row == row_w'(img_height - 1));
    assign row_near_last = (cur_row == row_w'(img_height - 2));

    // clamped row offsets, 1 means cur_row itself
    assign row_off[0] = row_first ? 2'd1 : 2'd0;
    assign row_off[1] = 2'd1;
    assign row_off[2] = row_last ? 2'd1 : 2'd2;
    assign row_off[3] = row_last ? 2'd1 : (row_near_last ? 2'd2 : 2'd3);

    always_comb begin
        for (int i = 0; i < win_size; i++) begin
            row_bank[i] = bank_of(cur_bank, row_off[i]);
            row_pix[i]  = bank_data[row_bank[i]];
        end
    end

    assign hold     = win_valid && !win_ready;
    assign xfer     = win_valid && win_ready;
    assign row_done = xfer && win_last;
    assign active   = (rd_state == rd_prime) ||
                      ((rd_state == rd_run) && (rd_k < k_w'(img_width + 3)));
    assign rd_en    = active && !hold;
    assign shift    = rd_pend && !hold;

    // column clamp(k-1)
    always_comb begin
        if (rd_k == '0) begin
            rd_col = '0;
        end else if (rd_k > k_w'(img_width)) begin
            rd_col = k_w'(img_width - 1);
        end else begin
            rd_col = rd_k - 1'b1;
        end
    end
    assign rd_addr = addr_w'(rd_col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state  <= rd_wait;
            cur_row   <= '0;
            cur_bank  <= '0;
            rd_k      <= '0;
            rd_pend   <= 1'b0;
            pend_win  <= 1'b0;
            pend_last <= 1'b0;
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_k      <= rd_k + 1'b1;
                rd_pend   <= 1'b1;
                pend_win  <= (rd_k >= k_w'(3));
                pend_last <= (rd_k == k_w'(img_width + 2));
            end else if (shift) begin
                rd_pend <= 1'b0;
            end

            if (shift && pend_win) begin
                win_valid <= 1'b1;
                win_last  <= pend_last;
            end else if (xfer) begin
                win_valid <= 1'b0;
            end

            case (rd_state)
                rd_wait: begin
                    if (rows_ready) begin
                        rd_state <= rd_prime;
                    end
                end
                rd_prime: begin
                    if (rd_en && (rd_k == k_w'(2))) begin
                        rd_state <= rd_run;
                    end
                end
                rd_run: begin
                    if (row_done) begin
                        rd_k     <= '0;
                        cur_bank <= (cur_bank == bank_sel_t'(num_banks - 1)) ? '0
                                                                            : cur_bank + 1'b1;
                        if (row_last) begin
                            rd_state <= rd_last;
                        end else begin
                            rd_state <= rd_wait;
                            cur_row  <= cur_row + 1'b1;
                        end
                    end
                end
                default: begin  // rd_last
                    rd_state <= rd_wait;
                    cur_row  <= '0;
                end
            endcase
        end
    end

    // new column enters at j=3, oldest column leaves at j=0
    always_ff @(posedge clk) begin
        if (shift) begin
            for (int i = 0; i < win_size; i++) begin
                for (int j = 0; j < win_size - 1; j++) begin
                    win_q[i][j] <= win_q[i][j+1];
                end
                win_q[i][win_size-1] <= row_pix[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < win_size; i++) begin
            for (int j = 0; j < win_size; j++) begin
                win_pix[(i*win_size+j)*pixel_width +: pixel_width] = win_q[i][j];
            end
        end
    end

    assign frame_done = (rd_state == rd_last);

    a_win_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (win_valid && !win_ready) |=> (win_valid && $stable(win_pix)));

endmodule

// File: hdl/line_buffer_top.sv
// bicubic line buffer top: writer, five row memories and window reader wired together
`timescale 1ns/1ps

module line_buffer_top #(
    parameter int img_width   = 8,
    parameter int img_height  = 6,
    parameter int pixel_width = 24
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [pixel_width-1:0] in_pix,
    output logic                   win_valid,
    input  logic                   win_ready,
    output logic [line_buf_pkg::win_size*line_buf_pkg::win_size*pixel_width-1:0] win_pix,
    output logic                   frame_done
);
    import line_buf_pkg::*;

    localparam int addr_w = (img_width > 1) ? $clog2(img_width) : 1;
    localparam int row_w  = $clog2(img_height + 1);

    logic [num_banks-1:0]   wr_en;
    logic [addr_w-1:0]      wr_addr;
    logic [pixel_width-1:0] wr_data;
    logic                   rd_en;
    logic [addr_w-1:0]      rd_addr;
    logic [pixel_width-1:0] rd_data [num_banks];
    logic [row_w-1:0]       rows_written;
    logic [row_w-1:0]       cur_row;

    row_writer #(
        .img_width  (img_width),
        .img_height (img_height),
        .pixel_width(pixel_width)
    ) u_row_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_pix      (in_pix),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rows_written(rows_written),
        .cur_row     (cur_row),
        .frame_done  (frame_done)
    );

    // write data and read address are shared, wr_en picks the bank
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        row_ram #(
            .depth     (img_width),
            .data_width(pixel_width)
        ) u_row_ram (
            .clk    (clk),
            .wr_en  (wr_en[b]),
            .wr_addr(wr_addr),
            .wr_data(wr_data),
            .rd_en  (rd_en),
            .rd_addr(rd_addr),
            .rd_data(rd_data[b])
        );
    end

    window_reader #(
        .img_width  (img_width),
        .img_height (img_height),
        .pixel_width(pixel_width)
    ) u_window_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .rows_written(rows_written),
        .cur_row     (cur_row),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data0    (rd_data[0]),
        .rd_data1    (rd_data[1]),
        .rd_data2    (rd_data[2]),
        .rd_data3    (rd_data[3]),
        .rd_data4    (rd_data[4]),
        .win_valid   (win_valid),
        .win_ready   (win_ready),
        .win_pix     (win_pix),
        .frame_done  (frame_done)
    );

endmodule

// File: tb/window_model.svh
// reference model for the line buffer testbench, included in the testbench module body
`ifndef WINDOW_MODEL_SVH
`define WINDOW_MODEL_SVH

pix_t frame_mem [img_height][img_width];  // frame currently being sent

// nearest edge index for rows or columns outside the image
function automatic int clamp_index(int idx, int limit);
    if (idx < 0) begin
        return 0;
    end
    if (idx > limit - 1) begin
        return limit - 1;
    end
    return idx;
endfunction

// 4x4 neighbourhood of (r, c), element (i, j) at index i*4+j
function automatic win_t expected_window(int r, int c);
    win_t win;
    int   row;
    int   col;
    win = '0;
    for (int i = 0; i < win_size; i++) begin
        for (int j = 0; j < win_size; j++) begin
            row = clamp_index(r - 1 + i, img_height);
            col = clamp_index(c - 1 + j, img_width);
            win[(i * win_size + j) * pixel_width +: pixel_width] = frame_mem[row][col];
        end
    end
    return win;
endfunction

// all windows of the stored frame, row by row
task automatic queue_windows();
    for (int r = 0; r < img_height; r++) begin
        for (int c = 0; c < img_width; c++) begin
            expect_q.push_back(expected_window(r, c));
        end
    end
endtask

`endif

// File: tb/tb_line_buffer.sv
// testbench for the bicubic line buffer: random frames and stalls, checked against a window model
`timescale 1ns/1ps

module tb_line_buffer;
    import line_buf_pkg::*;

    localparam int img_width   = 8;
    localparam int img_height  = 6;
    localparam int pixel_width = 24;
    localparam int win_bits    = win_size * win_size * pixel_width;
    localparam int frame_wins  = img_width * img_height;
    localparam int stall_limit = 1000;  // cycles without progress

    typedef logic [pixel_width-1:0] pix_t;
    typedef logic [win_bits-1:0]    win_t;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    pix_t in_pix;
    logic win_valid;
    logic win_ready;
    win_t win_pix;
    logic frame_done;

    pix_t pix_q[$];
    win_t expect_q[$];

    int   errors       = 0;
    int   checks       = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    int   frames_sent  = 0;
    int   xfer_count   = 0;
    int   done_count   = 0;
    int   done_errors  = 0;
    int   hold_cycles  = 0;
    bit   done_due     = 1'b0;  // last window of a frame moved on the edge before
    bit   held_prev    = 1'b0;
    win_t held_pix;

    `include "window_model.svh"

    line_buffer_top #(
        .img_width  (img_width),
        .img_height (img_height),
        .pixel_width(pixel_width)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pix    (in_pix),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_pix   (win_pix),
        .frame_done(frame_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // frame_done timing and held windows, sampled between edges
    always @(negedge clk) begin
        if (rst_n) begin
            assert (frame_done == done_due) else begin
                $display("error: %0t frame_done got %b expected %b", $time, frame_done, done_due);
                errors++;
                done_errors++;
            end
            if (frame_done) begin
                done_count++;
            end
            if (held_prev) begin
                assert (win_valid) else begin
                    $display("error: %0t win_valid got %b expected 1", $time, win_valid);
                    errors++;
                end
                assert (win_pix == held_pix) else begin
                    $display("error: %0t win_pix got %h expected %h", $time, win_pix, held_pix);
                    errors++;
                end
            end
            done_due = 1'b0;
            if (win_valid && win_ready) begin
                xfer_count++;
                done_due = (xfer_count % frame_wins == 0);
            end
            held_prev = win_valid && !win_ready;
            if (held_prev) begin
                hold_cycles++;
            end
            held_pix = win_pix;
        end
    end

    task automatic build_frame();
        for (int r = 0; r < img_height; r++) begin
            for (int c = 0; c < img_width; c++) begin
                frame_mem[r][c] = pix_t'($urandom);
                pix_q.push_back(frame_mem[r][c]);
            end
        end
        queue_windows();
    endtask

    task automatic send_pixels(input bit gaps);
        int idx;
        int stall;
        idx = 0;
        stall = 0;
        while (idx < pix_q.size() && stall < stall_limit) begin
            @(posedge clk);
            in_valid <= !gaps || ($urandom_range(3) != 0);
            in_pix   <= pix_q[idx];
            @(negedge clk);
            if (in_valid && in_ready) begin  // moves on the next rising edge
                idx++;
                stall = 0;
            end else begin
                stall++;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        if (idx < pix_q.size()) begin
            $display("timeout: input stalled after %0d of %0d pixels", idx, pix_q.size());
            errors++;
        end
    endtask

    task automatic receive_windows(input int count, input bit gaps);
        int   got;
        int   stall;
        win_t exp_win;
        got = 0;
        stall = 0;
        while (got < count && stall < stall_limit) begin
            @(posedge clk);
            win_ready <= !gaps || ($urandom_range(2) != 0);
            @(negedge clk);
            if (win_valid && win_ready) begin
                exp_win = expect_q.pop_front();
                checks++;
                assert (win_pix == exp_win) else begin
                    $display("error: %0t win_pix got %h expected %h", $time, win_pix, exp_win);
                    errors++;
                end
                got++;
                stall = 0;
            end else begin
                stall++;
            end
        end
        @(posedge clk);
        win_ready <= 1'b0;
        if (got < count) begin
            $display("timeout: only %0d of %0d windows arrived", got, count);
            errors++;
        end
    endtask

    task automatic wait_frame_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < stall_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (done_count < target) begin
            $display("timeout: frame_done never pulsed for frame %0d", target);
            errors++;
        end
    endtask

    task automatic run_frames(input int frames, input bit in_gaps, input bit out_gaps);
        for (int f = 0; f < frames; f++) begin
            build_frame();
        end
        frames_sent += frames;
        fork
            send_pixels(in_gaps);
            receive_windows(frames * frame_wins, out_gaps);
        join
        wait_frame_done(frames_sent);
        pix_q.delete();
        expect_q.delete();
    endtask

    task automatic check_idle();
        for (int n = 0; n < 4; n++) begin
            @(negedge clk);
            assert (in_ready) else begin
                $display("error: %0t in_ready got %b expected 1", $time, in_ready);
                errors++;
            end
            assert (!win_valid) else begin
                $display("error: %0t win_valid got %b expected 0", $time, win_valid);
                errors++;
            end
            assert (!frame_done) else begin
                $display("error: %0t frame_done got %b expected 0", $time, frame_done);
                errors++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - err_start);
        end
    endtask

    initial begin
        int mark;
        void'($urandom(38289));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pix    = '0;
        win_ready = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        mark = errors;
        check_idle();
        report_test(1, "reset state", mark);

        mark = errors;
        run_frames(1, 1'b0, 1'b0);
        report_test(2, "single frame without stalls", mark);

        mark = errors;
        hold_cycles = 0;
        run_frames(1, 1'b1, 1'b1);
        assert (hold_cycles > 0) else begin
            $display("no back-pressure cycles were seen on the output");
            errors++;
        end
        report_test(3, "single frame with stalls", mark);

        mark = errors;
        run_frames(3, 1'b0, 1'b1);  // writer must wait for the reader here
        report_test(4, "three back-to-back frames", mark);

        mark = errors;
        assert (done_count == frames_sent && done_errors == 0) else begin
            $display("frame_done pulsed %0d times for %0d frames, %0d timing errors",
                     done_count, frames_sent, done_errors);
            errors++;
        end
        report_test(5, "frame_done pulses", mark);

        $display("tests run %0d, failed %0d, window checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tb
hdl/line_buf_pkg.sv
hdl/row_ram.sv
hdl/row_writer.sv
hdl/window_reader.sv
hdl/line_buffer_top.sv
tb/tb_line_buffer.sv

// File: Makefile
# Verilator build and run of the line buffer testbench

TOP  = tb_line_buffer
SRCS = $(wildcard hdl/*.sv tb/*.sv tb/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log
